// File: common/eth_consts.svh
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

// MDIO frame header fields
`define PHY_ADDR        5'd1    // strap address of the external PHY
`define PHY_STATUS_REG  5'd17   // PHY-specific status register

// management timing, in gmii_txc cycles
`define MDC_HALF_DIV    4       // clocks per MDC half period
`define POLL_INTERVAL   200     // gap between end of frame and next start

`endif

// File: common/eth_mgmt_pkg.sv
package eth_mgmt_pkg;

    // PHY status register 17 layout
    typedef struct packed {
        logic [1:0]  speed;     // 10 gigabit, 01 100M, 00 10M
        logic        duplex;    // 1 full, 0 half
        logic [1:0]  rsvd_hi;
        logic        link;      // real-time link state
        logic [9:0]  rsvd_lo;
    } phy_status_t;

    // word shifted in off MDIO, decoded through the struct view
    typedef union packed {
        logic [15:0] raw;
        phy_status_t st;
    } phy_status_word_u;

    // link report towards the MAC side
    typedef struct packed {
        logic        valid;     // one-cycle pulse per completed poll
        logic        link;
        logic [1:0]  speed;
        logic        duplex;
    } link_info_t;

endpackage

// File: common/eth_data_pkg.sv
package eth_data_pkg;

    // GMII byte with single-cycle strobe
    typedef struct packed {
        logic        en;        // byte valid this cycle
        logic [7:0]  data;
    } gmii_byte_t;

    // RGMII nibble as seen in nibble-per-cycle mode
    typedef struct packed {
        logic        ctl;       // data valid
        logic [3:0]  d;
    } rgmii_nib_t;

endpackage

// File: miim/miim_poller.sv
`timescale 1ns/100ps
`include "eth_consts.svh"

module miim_poller (
    input  logic                     gmii_txc,
    input  logic                     rst,
    output logic                     mdc,
    output logic                     mdio_o,
    output logic                     mdio_oe,
    input  logic                     mdio_i,
    output eth_mgmt_pkg::link_info_t link
);

    import eth_mgmt_pkg::*;

    localparam int unsigned poll_w = $clog2(`POLL_INTERVAL);
    localparam int unsigned div_w  = $clog2(`MDC_HALF_DIV + 1);

    // preamble, start, read opcode, phy address, register
    localparam logic [45:0] frame_hdr = {32'hffff_ffff, 2'b01, 2'b10,
                                         `PHY_ADDR, `PHY_STATUS_REG};

    logic                in_frame;
    logic [poll_w-1:0]   poll_cnt;
    logic [div_w-1:0]    div_cnt;
    logic [5:0]          bit_cnt;   // MDC period within the frame
    logic [5:0]          bit_nxt;
    phy_status_word_u    rx_word;
    phy_status_word_u    next_word;

    // header bit for a given MDC period, zero once the bus is released
    function automatic logic hdr_bit(input logic [5:0] n);
        logic [5:0] idx;
        idx = 6'd45 - n;
        if (n < 6'd46) begin
            return frame_hdr[idx];
        end
        return 1'b0;
    endfunction

    assign bit_nxt = bit_cnt + 6'd1;

    always_comb begin
        next_word.raw = {rx_word.raw[14:0], mdio_i};  // msb arrives first
    end

    always_ff @(posedge gmii_txc) begin
        if (rst) begin
            in_frame <= 1'b0;
            poll_cnt <= '0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            mdc      <= 1'b0;
            mdio_o   <= 1'b1;
            mdio_oe  <= 1'b0;
            link     <= '0;
        end else begin
            link.valid <= 1'b0;
            if (!in_frame) begin
                if (poll_cnt == poll_w'(`POLL_INTERVAL - 1)) begin
                    poll_cnt <= '0;
                    in_frame <= 1'b1;
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    mdio_o   <= hdr_bit(6'd0);   // first preamble bit
                    mdio_oe  <= 1'b1;
                end else begin
                    poll_cnt <= poll_cnt + 1'b1;
                end
            end else if (div_cnt == div_w'(`MDC_HALF_DIV - 1)) begin
                div_cnt <= '0;
                mdc     <= ~mdc;
                if (!mdc) begin
                    // rising edge, PHY data is stable here
                    if (bit_cnt >= 6'd48) begin
                        rx_word.raw <= next_word.raw;
                    end
                    if (bit_cnt == 6'd63) begin
                        link <= '{valid:  1'b1,
                                  link:   next_word.st.link,
                                  speed:  next_word.st.speed,
                                  duplex: next_word.st.duplex};
                    end
                end else if (bit_cnt == 6'd63) begin
                    in_frame <= 1'b0;   // mdc back low, frame done
                    mdio_o   <= 1'b1;
                    mdio_oe  <= 1'b0;
                end else begin
                    // falling edge, present next bit
                    bit_cnt <= bit_nxt;
                    mdio_o  <= hdr_bit(bit_nxt);
                    mdio_oe <= (bit_nxt < 6'd46);  // released for TA and data
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // PHY owns the line from turnaround onwards
    a_oe_released: assert property (@(posedge gmii_txc) disable iff (rst)
        (in_frame && bit_cnt >= 6'd46) |-> !mdio_oe)
        else $error("mdio_oe high during turnaround or data");

    // divider keeps every MDC phase longer than one clock
    a_mdc_slow: assert property (@(posedge gmii_txc) disable iff (rst)
        (mdc != $past(mdc)) |=> (mdc == $past(mdc)))
        else $error("mdc toggled on successive clocks");

endmodule

// File: rgmii/gmii_to_rgmii.sv
`timescale 1ns/100ps

module gmii_to_rgmii (
    input  logic                     gmii_txc,
    input  logic                     rst,
    input  eth_data_pkg::gmii_byte_t gmii_tx,
    output eth_data_pkg::gmii_byte_t gmii_rx,
    output eth_data_pkg::rgmii_nib_t rgmii_tx,
    input  eth_data_pkg::rgmii_nib_t rgmii_rx
);

    import eth_data_pkg::*;

    logic        tx_hi_pend;    // high nibble still to go out
    logic [3:0]  tx_hi;
    logic        rx_phase;      // low nibble held, waiting for high
    logic [3:0]  rx_lo;
    logic        rx_en;
    logic [7:0]  rx_data;

    function automatic rgmii_nib_t data_nib(input logic [3:0] d);
        rgmii_nib_t n;
        n.ctl = 1'b1;
        n.d   = d;
        return n;
    endfunction

    // transmit, low nibble first then high nibble
    always_ff @(posedge gmii_txc) begin
        if (rst) begin
            tx_hi_pend <= 1'b0;
            rgmii_tx   <= '0;
        end else if (tx_hi_pend) begin
            rgmii_tx   <= data_nib(tx_hi);
            tx_hi_pend <= 1'b0;         // a strobe here is dropped
        end else if (gmii_tx.en) begin
            rgmii_tx   <= data_nib(gmii_tx.data[3:0]);
            tx_hi_pend <= 1'b1;
        end else begin
            rgmii_tx   <= '0;           // idle, ctl low
        end
    end

    always_ff @(posedge gmii_txc) begin
        if (gmii_tx.en && !tx_hi_pend) begin
            tx_hi <= gmii_tx.data[7:4];
        end
    end

    // receive, pair nibbles while ctl stays high
    always_ff @(posedge gmii_txc) begin
        if (rst) begin
            rx_phase <= 1'b0;
            rx_en    <= 1'b0;
        end else begin
            rx_en <= 1'b0;
            if (!rgmii_rx.ctl) begin
                rx_phase <= 1'b0;       // lone nibble discarded
            end else if (!rx_phase) begin
                rx_phase <= 1'b1;
            end else begin
                rx_phase <= 1'b0;
                rx_en    <= 1'b1;
            end
        end
    end

    always_ff @(posedge gmii_txc) begin
        if (rgmii_rx.ctl && !rx_phase) begin
            rx_lo <= rgmii_rx.d;
        end
        if (rgmii_rx.ctl && rx_phase) begin
            rx_data <= {rgmii_rx.d, rx_lo};
        end
    end

    assign gmii_rx.en   = rx_en;
    assign gmii_rx.data = rx_data;

    // source must leave a gap while the high nibble is sent
    a_tx_spacing: assert property (@(posedge gmii_txc) disable iff (rst)
        tx_hi_pend |-> !gmii_tx.en)
        else $error("gmii_tx strobe while high nibble pending");

endmodule

// File: hw/eth_top.sv
`timescale 1ns/100ps

module eth_top (
    input  logic                     gmii_txc,  // single system clock
    input  logic                     rst,

    // MAC side
    input  eth_data_pkg::gmii_byte_t gmii_tx,
    output eth_data_pkg::gmii_byte_t gmii_rx,

    // PHY data pins, nibble mode
    output eth_data_pkg::rgmii_nib_t rgmii_tx,
    input  eth_data_pkg::rgmii_nib_t rgmii_rx,

    // PHY management, pad lives at chip top
    output logic                     mdc,
    output logic                     mdio_o,
    output logic                     mdio_oe,
    input  logic                     mdio_i,

    output eth_mgmt_pkg::link_info_t link       // polled status
);

    // status polling of the PHY
    miim_poller u_miim (
        .gmii_txc (gmii_txc),
        .rst      (rst),
        .mdc      (mdc),
        .mdio_o   (mdio_o),
        .mdio_oe  (mdio_oe),
        .mdio_i   (mdio_i),
        .link     (link)
    );

    // byte to nibble conversion, both directions
    gmii_to_rgmii u_conv (
        .gmii_txc (gmii_txc),
        .rst      (rst),
        .gmii_tx  (gmii_tx),
        .gmii_rx  (gmii_rx),
        .rgmii_tx (rgmii_tx),
        .rgmii_rx (rgmii_rx)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;                // released after 8 cycles
    end

endmodule

// File: testbench/phy_model.sv
`timescale 1ns/100ps

module phy_model (
    input  logic                     clk,
    input  logic                     mdc,
    input  logic                     mdio_o,
    input  logic                     mdio_oe,
    output logic                     mdio_i,
    input  logic [15:0]              status,    // word returned on each read
    input  eth_data_pkg::rgmii_nib_t rgmii_tx,
    output eth_data_pkg::rgmii_nib_t rgmii_rx,
    output logic [45:0]              hdr,       // preamble and header as seen
    output logic [6:0]               per        // MDC period within the frame
);

    logic        mdc_q   = 1'b0;
    logic        oe_q    = 1'b0;
    logic        mdio_q  = 1'b1;
    logic [6:0]  per_q   = 7'd64;
    logic [45:0] hdr_q   = '0;
    logic [15:0] tx_word = 16'hffff;
    logic [6:0]  per_nxt;

    assign rgmii_rx = rgmii_tx;     // cable loopback
    assign mdio_i   = mdio_q;
    assign per      = per_q;
    assign hdr      = hdr_q;
    assign per_nxt  = per_q + 7'd1;

    always @(posedge clk) begin
        mdc_q <= mdc;
        oe_q  <= mdio_oe;
        if (mdio_oe && !oe_q) begin
            per_q   <= 7'd0;        // poller took the line, new frame
            tx_word <= status;
        end else if (mdc && !mdc_q) begin
            if (per_q < 7'd46) begin
                hdr_q <= {hdr_q[44:0], mdio_o};
            end
        end else if (!mdc && mdc_q) begin
            per_q <= per_nxt;
            if (per_nxt >= 7'd48 && per_nxt <= 7'd63) begin
                mdio_q  <= tx_word[15];     // msb first
                tx_word <= {tx_word[14:0], 1'b1};
            end else begin
                mdio_q <= 1'b1;             // pull-up level
            end
        end
    end

endmodule

// File: testbench/eth_tb.sv
`timescale 1ns/100ps
`include "eth_consts.svh"

module eth_tb;

    import eth_data_pkg::*;
    import eth_mgmt_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'hcccb_98a9;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    // gigabit full up, 100M half up, link down (reserved bits set)
    localparam logic [15:0] test_words [3] = '{16'hac05, 16'h4400, 16'ha3ff};

    logic        gmii_txc;
    logic        rst;
    gmii_byte_t  gmii_tx;
    gmii_byte_t  gmii_rx;
    rgmii_nib_t  rgmii_tx;
    rgmii_nib_t  rgmii_rx;
    logic        mdc;
    logic        mdio_o;
    logic        mdio_oe;
    logic        mdio_i;
    link_info_t  link;
    logic [15:0] status_word;
    logic [45:0] phy_hdr;
    logic [6:0]  phy_per;
    logic [31:0] lfsr     = lfsr_seed;
    gmii_byte_t  hist1    = '0;     // gmii_tx seen 1, 2 and 3 negedges ago
    gmii_byte_t  hist2    = '0;
    gmii_byte_t  hist3    = '0;
    rgmii_nib_t  exp_nib;
    logic        quiet    = 1'b1;   // no strobe sent yet
    int          errors   = 0;
    int          timeouts = 0;

    tb_clock_gen u_clk (.clk(gmii_txc), .rst(rst));

    eth_top u_dut (
        .gmii_txc (gmii_txc),
        .rst      (rst),
        .gmii_tx  (gmii_tx),
        .gmii_rx  (gmii_rx),
        .rgmii_tx (rgmii_tx),
        .rgmii_rx (rgmii_rx),
        .mdc      (mdc),
        .mdio_o   (mdio_o),
        .mdio_oe  (mdio_oe),
        .mdio_i   (mdio_i),
        .link     (link)
    );

    phy_model u_phy (
        .clk      (gmii_txc),
        .mdc      (mdc),
        .mdio_o   (mdio_o),
        .mdio_oe  (mdio_oe),
        .mdio_i   (mdio_i),
        .status   (status_word),
        .rgmii_tx (rgmii_tx),
        .rgmii_rx (rgmii_rx),
        .hdr      (phy_hdr),
        .per      (phy_per)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);     // one step per bit
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (rst && n < limit) begin
            @(negedge gmii_txc);
            n++;
        end
        if (rst) begin
            $display("timeout: reset still asserted after %0d cycles", limit);
            timeouts++;
        end
    endtask

    task automatic wait_link_valid(input int limit);
        int n;
        n = 0;
        @(negedge gmii_txc);            // step past any pulse still showing
        while (!link.valid && n < limit) begin
            @(negedge gmii_txc);
            n++;
        end
        if (!link.valid) begin
            $display("timeout: no link.valid pulse within %0d cycles at %0t", limit, $time);
            timeouts++;
        end
    endtask

    // all checks sample at the falling edge, away from the driving edge
    always @(negedge gmii_txc) begin
        if (!rst) begin
            if (gmii_tx.en) begin
                quiet = 1'b0;
            end
            if (quiet) begin
                assert (!mdc) else report_mismatch("mdc", 0, 32'(mdc));
                assert (!mdio_oe) else report_mismatch("mdio_oe", 0, 32'(mdio_oe));
                assert (!link.valid) else report_mismatch("link.valid", 0, 32'(link.valid));
            end
            if (hist1.en) begin
                exp_nib = '{ctl: 1'b1, d: hist1.data[3:0]};
            end else if (hist2.en) begin
                exp_nib = '{ctl: 1'b1, d: hist2.data[7:4]};
            end else begin
                exp_nib = '0;           // idle between bytes
            end
            assert (rgmii_tx == exp_nib)
                else report_mismatch("rgmii_tx", 32'(exp_nib), 32'(rgmii_tx));
            assert (gmii_rx.en == hist3.en)
                else report_mismatch("gmii_rx.en", 32'(hist3.en), 32'(gmii_rx.en));
            if (hist3.en) begin
                assert (gmii_rx.data == hist3.data)
                    else report_mismatch("gmii_rx.data", 32'(hist3.data), 32'(gmii_rx.data));
            end
            if (phy_per >= 7'd46 && phy_per <= 7'd63) begin
                assert (!mdio_oe) else report_mismatch("mdio_oe", 0, 32'(mdio_oe));
            end
            if (link.valid) begin
                assert (link.link == status_word[10])
                    else report_mismatch("link.link", 32'(status_word[10]), 32'(link.link));
                assert (link.speed == status_word[15:14])
                    else report_mismatch("link.speed", 32'(status_word[15:14]),
                                         32'(link.speed));
                assert (link.duplex == status_word[13])
                    else report_mismatch("link.duplex", 32'(status_word[13]),
                                         32'(link.duplex));
                assert (phy_hdr[45:14] == 32'hffff_ffff)
                    else report_mismatch("mdio preamble", 32'hffff_ffff, phy_hdr[45:14]);
                assert (phy_hdr[13:0] == {2'b01, 2'b10, `PHY_ADDR, `PHY_STATUS_REG})
                    else report_mismatch("mdio header",
                        32'({2'b01, 2'b10, `PHY_ADDR, `PHY_STATUS_REG}), 32'(phy_hdr[13:0]));
            end
            hist3 = hist2;
            hist2 = hist1;
            hist1 = gmii_tx;
        end
    end

    initial begin
        logic [7:0] b;
        logic [7:0] gap;
        gmii_tx     = '0;
        status_word = 16'h0000;
        wait_reset_release(20);
        repeat (30) @(posedge gmii_txc);
        for (int k = 0; k < 40; k++) begin
            take_bits(8, b);
            take_bits(2, gap);
            @(posedge gmii_txc);
            gmii_tx <= '{en: 1'b1, data: b};
            @(posedge gmii_txc);
            gmii_tx.en <= 1'b0;
            repeat (gap) @(posedge gmii_txc);   // strobes 2 to 5 cycles apart
        end
        wait_link_valid(2000);          // first poll returns the zero word
        for (int k = 0; k < 3; k++) begin
            @(posedge gmii_txc);
            status_word <= test_words[k];
            wait_link_valid(2000);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/eth_mgmt_pkg.sv
common/eth_data_pkg.sv
miim/miim_poller.sv
rgmii/gmii_to_rgmii.sv
hw/eth_top.sv
testbench/tb_clock_gen.sv
testbench/phy_model.sv
testbench/eth_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the Ethernet PHY-side testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module eth_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Veth_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only if the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
